// ==== common/ooo_settings.svh ====
// ooo back end sizes and operation codes shared by the RTL and the testbench
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// datapath and buffer sizes
//////////////////////////////////////////////////////////////////////

// operand and result width
`define OOO_XLEN 32

// reorder buffer entries, also the credits held after reset
`define OOO_ROB_DEPTH 8
// log2 of the depth
`define OOO_TAG_W 3

// multiplier latency in cycles, at least 2
`define OOO_MULT_STAGES 3

//////////////////////////////////////////////////////////////////////
// operation codes
//////////////////////////////////////////////////////////////////////

`define OOO_OP_ADD 3'd0
`define OOO_OP_SUB 3'd1
`define OOO_OP_AND 3'd2
`define OOO_OP_XOR 3'd3
`define OOO_OP_MUL 3'd4

`endif

// ==== common/ooo_pkg.sv ====
// shared value types and packets of the out-of-order back end
`include "ooo_settings.svh"

package ooo_pkg;

	//////////////////////////////////////////////////////////////////////
	// plain vectors with a meaning
	//////////////////////////////////////////////////////////////////////

	// operand or result value
	typedef logic [`OOO_XLEN-1:0] data_t;

	// reorder buffer slot index
	typedef logic [`OOO_TAG_W-1:0] rob_tag_t;

	// architectural destination register
	typedef logic [4:0] reg_idx_t;

	// operation code, see the OOO_OP_* macros
	typedef logic [2:0] op_t;

	//////////////////////////////////////////////////////////////////////
	// packets between the blocks
	//////////////////////////////////////////////////////////////////////

	// decoded instruction with operand values already read
	typedef struct packed {
		op_t      op;
		data_t    operand_a;
		data_t    operand_b;
		reg_idx_t dest;
	} issue_packet_t;

	// result from one execution path back to the reorder buffer
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		data_t    value;
	} wb_packet_t;

	// retired instruction, in program order
	typedef struct packed {
		reg_idx_t dest;
		data_t    value;
	} commit_packet_t;

endpackage

// ==== hdl/alu_unit.sv ====
// single-cycle integer ALU with a registered writeback to the reorder buffer
`include "ooo_settings.svh"

module alu_unit import ooo_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  logic          issue_valid,
	input  issue_packet_t issue,
	input  rob_tag_t      alloc_tag,
	output wb_packet_t    alu_wb
);

	// decode and compute in the issue cycle
	logic  is_alu;
	data_t result;

	always_comb begin
		is_alu = 1'b1;
		case (issue.op)
			`OOO_OP_ADD: result = issue.operand_a + issue.operand_b;
			`OOO_OP_SUB: result = issue.operand_a - issue.operand_b;
			`OOO_OP_AND: result = issue.operand_a & issue.operand_b;
			`OOO_OP_XOR: result = issue.operand_a ^ issue.operand_b;
			default: begin
				// multiply or illegal, not ours
				is_alu = 1'b0;
				result = '0;
			end
		endcase
	end

	// writeback register, valid for one cycle
	always_ff @(posedge clock) begin
		alu_wb.tag   <= alloc_tag;
		alu_wb.value <= result;
		if (reset) begin
			alu_wb.valid <= 1'b0;
		end else begin
			alu_wb.valid <= issue_valid && is_alu;
		end
	end

	// every issued code must belong to one of the two paths
	a_known_op: assert property (@(posedge clock) disable iff (reset)
		issue_valid |-> !$isunknown(issue.op) &&
			(is_alu || issue.op == `OOO_OP_MUL))
		else $error("alu_unit: unknown op %0d issued", issue.op);

endmodule

// ==== mult/mult_unit.sv ====
// pipelined multiplier with fixed latency, one new multiply per cycle
`include "ooo_settings.svh"

module mult_unit import ooo_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  logic          issue_valid,
	input  issue_packet_t issue,
	input  rob_tag_t      alloc_tag,
	output wb_packet_t    mult_wb
);

	// product built from two half-width partial products
	localparam int HALF = `OOO_XLEN / 2;

	logic is_mul_issue;

	// per-stage valid, tag and partial value
	wb_packet_t stage_q [`OOO_MULT_STAGES];

	// operands kept for the upper partial product in stage 1
	data_t           a_q;
	logic [HALF-1:0] b_hi_q;

	assign is_mul_issue = issue_valid && (issue.op == `OOO_OP_MUL);

	//////////////////////////////////////////////////////////////////////
	// pipeline
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		// stage 0: a times low half of b
		stage_q[0].tag   <= alloc_tag;
		stage_q[0].value <= issue.operand_a * issue.operand_b[HALF-1:0];
		a_q              <= issue.operand_a;
		b_hi_q           <= issue.operand_b[`OOO_XLEN-1:HALF];

		// stage 1: add the shifted upper partial product, low bits only
		stage_q[1].tag   <= stage_q[0].tag;
		stage_q[1].value <= stage_q[0].value + ((a_q * b_hi_q) << HALF);

		// remaining stages only delay the finished product
		for (int i = 2; i < `OOO_MULT_STAGES; i++) begin
			stage_q[i].tag   <= stage_q[i-1].tag;
			stage_q[i].value <= stage_q[i-1].value;
		end

		if (reset) begin
			for (int i = 0; i < `OOO_MULT_STAGES; i++) begin
				stage_q[i].valid <= 1'b0;
			end
		end else begin
			stage_q[0].valid <= is_mul_issue;
			for (int i = 1; i < `OOO_MULT_STAGES; i++) begin
				stage_q[i].valid <= stage_q[i-1].valid;
			end
		end
	end

	// last stage feeds the reorder buffer directly
	assign mult_wb = stage_q[`OOO_MULT_STAGES-1];

	// fixed latency: a result leaves exactly OOO_MULT_STAGES cycles after issue
	a_fixed_latency: assert property (@(posedge clock) disable iff (reset)
		mult_wb.valid == $past(is_mul_issue, `OOO_MULT_STAGES))
		else $error("mult_unit: writeback valid out of step with issue");

endmodule

// ==== rob/rob.sv ====
// reorder buffer, allocates tags, collects both writebacks, retires in order
`include "ooo_settings.svh"

module rob import ooo_pkg::*; (
	input  logic           clock,
	input  logic           reset,
	input  logic           issue_valid,
	input  issue_packet_t  issue,
	input  wb_packet_t     alu_wb,
	input  wb_packet_t     mult_wb,
	output rob_tag_t       alloc_tag,
	output logic           commit_valid,
	output commit_packet_t commit,
	output logic           credit_return
);

	//////////////////////////////////////////////////////////////////////
	// entry state
	//////////////////////////////////////////////////////////////////////

	// control bits per entry
	logic [`OOO_ROB_DEPTH-1:0] busy;
	logic [`OOO_ROB_DEPTH-1:0] done;

	// payload per entry
	reg_idx_t dest_mem  [`OOO_ROB_DEPTH];
	data_t    value_mem [`OOO_ROB_DEPTH];

	// circular pointers, tag width wraps at the depth
	rob_tag_t head;
	rob_tag_t tail;

	// one extra bit so full and empty differ
	logic [`OOO_TAG_W:0] count;

	logic commit_fire;

	// oldest entry finished
	assign commit_fire = busy[head] && done[head];

	// next free slot goes to both paths
	assign alloc_tag = tail;

	//////////////////////////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			busy          <= '0;
			done          <= '0;
			head          <= '0;
			tail          <= '0;
			count         <= '0;
			commit_valid  <= 1'b0;
			credit_return <= 1'b0;
		end else begin
			// allocate at the tail
			if (issue_valid) begin
				busy[tail] <= 1'b1;
				done[tail] <= 1'b0;
				tail       <= tail + 1'b1;
			end
			// both paths may finish in the same cycle, tags differ
			if (alu_wb.valid) begin
				done[alu_wb.tag] <= 1'b1;
			end
			if (mult_wb.valid) begin
				done[mult_wb.tag] <= 1'b1;
			end
			// retire the head
			if (commit_fire) begin
				busy[head] <= 1'b0;
				head       <= head + 1'b1;
			end
			// occupancy
			case ({issue_valid, commit_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// commit and credit leave together
			commit_valid  <= commit_fire;
			credit_return <= commit_fire;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// payload
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (issue_valid) begin
			dest_mem[tail] <= issue.dest;
		end
		if (alu_wb.valid) begin
			value_mem[alu_wb.tag] <= alu_wb.value;
		end
		if (mult_wb.valid) begin
			value_mem[mult_wb.tag] <= mult_wb.value;
		end
		// registered commit, only meaningful with commit_valid
		commit.dest  <= dest_mem[head];
		commit.value <= value_mem[head];
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// issuer ran past its credits
	a_no_alloc_full: assert property (@(posedge clock) disable iff (reset)
		issue_valid |-> count < `OOO_ROB_DEPTH)
		else $error("rob: allocation while full");

	// a result must land on a waiting entry
	a_alu_wb_target: assert property (@(posedge clock) disable iff (reset)
		alu_wb.valid |-> busy[alu_wb.tag] && !done[alu_wb.tag])
		else $error("rob: alu writeback to idle entry %0d", alu_wb.tag);

	a_mult_wb_target: assert property (@(posedge clock) disable iff (reset)
		mult_wb.valid |-> busy[mult_wb.tag] && !done[mult_wb.tag])
		else $error("rob: mult writeback to idle entry %0d", mult_wb.tag);

	// two paths never finish the same instruction
	a_wb_tag_clash: assert property (@(posedge clock) disable iff (reset)
		!(alu_wb.valid && mult_wb.valid && alu_wb.tag == mult_wb.tag))
		else $error("rob: both writebacks name tag %0d", alu_wb.tag);

endmodule

// ==== hdl/ooo_core.sv ====
// out-of-order back end top, issue into ALU and multiplier, in-order commit
`include "ooo_settings.svh"

module ooo_core import ooo_pkg::*; (
	input  logic           clock,
	input  logic           reset,
	input  logic           issue_valid,
	input  issue_packet_t  issue,
	output logic           credit_return,
	output logic           commit_valid,
	output commit_packet_t commit
);

	// tag of the slot taken by this cycle's issue
	rob_tag_t alloc_tag;

	// results from the two paths
	wb_packet_t alu_wb;
	wb_packet_t mult_wb;

	//////////////////////////////////////////////////////////////////////
	// execution paths, both see every issue
	//////////////////////////////////////////////////////////////////////

	alu_unit alu_0 (
		.clock      (clock),
		.reset      (reset),
		.issue_valid(issue_valid),
		.issue      (issue),
		.alloc_tag  (alloc_tag),
		.alu_wb     (alu_wb)
	);

	mult_unit mult_0 (
		.clock      (clock),
		.reset      (reset),
		.issue_valid(issue_valid),
		.issue      (issue),
		.alloc_tag  (alloc_tag),
		.mult_wb    (mult_wb)
	);

	// merge point and in-order retire
	rob rob_0 (
		.clock        (clock),
		.reset        (reset),
		.issue_valid  (issue_valid),
		.issue        (issue),
		.alu_wb       (alu_wb),
		.mult_wb      (mult_wb),
		.alloc_tag    (alloc_tag),
		.commit_valid (commit_valid),
		.commit       (commit),
		.credit_return(credit_return)
	);

endmodule

// ==== verification/ooo_core_tb.sv ====
// testbench for the ooo back end, random credit-limited issue against a reference queue
`include "ooo_settings.svh"

module ooo_core_tb import ooo_pkg::*; ();

	localparam int NUM_INSTR   = 300;
	localparam int ISSUE_LIMIT = 6000;
	localparam int DRAIN_LIMIT = 200;
	localparam int PROD_W      = 2 * `OOO_XLEN;

	// one expected retirement, op kept to pick the right check
	typedef struct packed {
		op_t            op;
		commit_packet_t pkt;
	} expect_t;

	logic           clock;
	logic           reset;
	logic           issue_valid;
	issue_packet_t  issue;
	logic           credit_return;
	logic           commit_valid;
	commit_packet_t commit;

	// reference model state, all updated on the falling edge
	expect_t exp_q[$];
	expect_t exp_head;
	bit      exp_avail;
	bit      pop_pending;
	bit      issued_any;
	int      credits;
	int      n_issued;
	int      n_commits;
	int      mul_burst;

	ooo_core dut_i (
		.clock        (clock),
		.reset        (reset),
		.issue_valid  (issue_valid),
		.issue        (issue),
		.credit_return(credit_return),
		.commit_valid (commit_valid),
		.commit       (commit)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// error reporting
	//////////////////////////////////////////////////////////////////////

	task automatic fail_run();
		$display("TESTS FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_mismatch(input string name, input data_t expected, input data_t actual);
		$display("ERR %s expected %h actual %h", name, expected, actual);
		fail_run();
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		fail_run();
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model and stimulus
	//////////////////////////////////////////////////////////////////////

	// result straight from the operation rules, product taken at full width
	function automatic data_t expected_value(input op_t op, input data_t a, input data_t b);
		logic [PROD_W-1:0] product;
		product = PROD_W'(a) * PROD_W'(b);
		case (op)
			`OOO_OP_ADD: return a + b;
			`OOO_OP_SUB: return a - b;
			`OOO_OP_AND: return a & b;
			`OOO_OP_XOR: return a ^ b;
			`OOO_OP_MUL: return product[`OOO_XLEN-1:0];
			default:     return '0;
		endcase
	endfunction

	// random op, with occasional bursts of multiplies back to back
	function automatic op_t next_op();
		if (mul_burst > 0) begin
			mul_burst--;
			return `OOO_OP_MUL;
		end
		if ($urandom_range(0, 7) == 0) begin
			mul_burst = 3;
		end
		case ($urandom_range(0, 4))
			0:       return `OOO_OP_ADD;
			1:       return `OOO_OP_SUB;
			2:       return `OOO_OP_AND;
			3:       return `OOO_OP_XOR;
			default: return `OOO_OP_MUL;
		endcase
	endfunction

	// one clock cycle of stimulus, run at the falling edge
	task automatic run_cycle(input bit want_issue);
		issue_packet_t pkt;
		expect_t       entry;
		@(negedge clock);
		// commit seen at the last rising edge has been checked, drop it
		if (pop_pending) begin
			n_commits++;
			if (exp_q.size() > 0) begin
				void'(exp_q.pop_front());
			end
		end
		if (credit_return) begin
			credits++;
		end
		if (want_issue && credits > 0) begin
			pkt.op        = next_op();
			pkt.operand_a = $urandom();
			pkt.operand_b = $urandom();
			pkt.dest      = reg_idx_t'($urandom_range(0, 31));
			entry.op        = pkt.op;
			entry.pkt.dest  = pkt.dest;
			entry.pkt.value = expected_value(pkt.op, pkt.operand_a, pkt.operand_b);
			exp_q.push_back(entry);
			issue       = pkt;
			issue_valid = 1'b1;
			credits--;
			n_issued++;
			issued_any = 1'b1;
		end else begin
			issue_valid = 1'b0;
		end
		// oldest outstanding instruction, compared at the next rising edge
		exp_avail = (exp_q.size() > 0);
		if (exp_avail) begin
			exp_head = exp_q[0];
		end
		pop_pending = commit_valid;
	endtask

	initial begin : stimulus
		int cycles;
		issue_valid = 1'b0;
		issue       = '0;
		reset       = 1'b1;
		credits     = `OOO_ROB_DEPTH;
		n_issued    = 0;
		n_commits   = 0;
		mul_burst   = 0;
		exp_avail   = 1'b0;
		pop_pending = 1'b0;
		issued_any  = 1'b0;
		exp_head    = '0;
		void'($urandom(32'h6c03));
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		// issue phase, idle gaps about one cycle in four
		cycles = 0;
		while (n_issued < NUM_INSTR && cycles < ISSUE_LIMIT) begin
			run_cycle($urandom_range(0, 3) != 0);
			cycles++;
		end
		if (n_issued < NUM_INSTR) begin
			report_problem("issue stalled, credits never came back");
		end else begin
			// drain phase
			cycles = 0;
			while ((exp_q.size() > 0 || credits != `OOO_ROB_DEPTH) && cycles < DRAIN_LIMIT) begin
				run_cycle(1'b0);
				cycles++;
			end
			if (exp_q.size() == 0 && credits == `OOO_ROB_DEPTH && n_commits == n_issued) begin
				$display("TESTS PASSED");
				$finish;
			end else begin
				report_problem("drain timed out or commit count differs from issue count");
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// quiet outputs through reset until something is issued
	a_reset_quiet: assert property (@(posedge clock)
		!issued_any |-> commit_valid !== 1'b1 && credit_return !== 1'b1)
		else report_problem("commit or credit pulse before the first issue");

	a_credit_pair: assert property (@(posedge clock) disable iff (reset)
		credit_return == commit_valid)
		else report_mismatch("credit_pair", data_t'($sampled(commit_valid)),
			data_t'($sampled(credit_return)));

	a_credit_range: assert property (@(posedge clock) disable iff (reset)
		credits >= 0 && credits <= `OOO_ROB_DEPTH)
		else report_problem("issuer credit count left its range");

	a_commit_expected: assert property (@(posedge clock) disable iff (reset)
		commit_valid |-> exp_avail)
		else report_problem("commit with no instruction outstanding");

	// program order, dest of the oldest issue
	a_order: assert property (@(posedge clock) disable iff (reset)
		commit_valid && exp_avail |-> commit.dest == exp_head.pkt.dest)
		else report_mismatch("program_order", data_t'(exp_head.pkt.dest),
			data_t'($sampled(commit.dest)));

	a_alu_value: assert property (@(posedge clock) disable iff (reset)
		commit_valid && exp_avail && exp_head.op != `OOO_OP_MUL |->
			commit.value == exp_head.pkt.value)
		else report_mismatch("alu_result", exp_head.pkt.value, $sampled(commit.value));

	a_mult_value: assert property (@(posedge clock) disable iff (reset)
		commit_valid && exp_avail && exp_head.op == `OOO_OP_MUL |->
			commit.value == exp_head.pkt.value)
		else report_mismatch("mult_result", exp_head.pkt.value, $sampled(commit.value));

endmodule

// ==== sim.f ====
+incdir+common
common/ooo_pkg.sv
hdl/alu_unit.sv
mult/mult_unit.sv
rob/rob.sv
hdl/ooo_core.sv
verification/ooo_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the ooo core testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -f sim.f --top-module ooo_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vooo_core_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTS PASSED" "$log"; then
	exit 0
fi
echo "pass line not found in $log"
exit 1
